/* Makefile */
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* src/cache_ctrl_pkg.sv */
// controller state encoding, imported by the miss-handling FSM and the protocol checker
`default_nettype none

package cache_ctrl_pkg;

	// --------------------------------------------------
	// controller states
	// --------------------------------------------------
	// idle       one cycle after reset, stall high, no strobes
	// compare    tag lookup, hits complete here
	// write back mem_write of the dirty victim line
	// allocate   mem_read of the requested line
	typedef enum logic [1:0] {
		ST_COMPARE    = 2'b00,
		ST_WRITE_BACK = 2'b01,
		ST_ALLOCATE   = 2'b10,
		ST_IDLE       = 2'b11
	} cache_state_e;

endpackage

`default_nettype wire

/* src/cache_fsm.sv */
// miss-handling FSM of the cache, driving the memory strobes, the stall and the array updates
`timescale 1ns/1ps
`default_nettype none

module cache_fsm import cache_geom_pkg::*, cache_ctrl_pkg::*; #(
	parameter int NUM_LINES = 8
) (
	input logic clk,
	input logic proc_reset,

	// processor request levels
	input logic proc_read,
	input logic proc_write,

	// lookup of the addressed index
	input logic hit,
	input logic line_dirty,

	// one-cycle answer from memory
	input logic mem_ready,

	// victim line for write-back
	input line_t victim_line,
	input mem_addr_t victim_mem_addr,

	// request address, for the allocate line address
	input proc_addr_t proc_addr,

	output logic proc_stall,

	// memory port
	output logic mem_read,
	output logic mem_write,
	output mem_addr_t mem_addr,
	output line_t mem_wdata,

	// array update strobes
	output logic word_write_en,
	output logic fill_en,
	output logic clean_en
);

	// --------------------------------------------------
	// geometry check
	// --------------------------------------------------

	// index width comes from log2 of the line count
	if (NUM_LINES < 2 || (NUM_LINES & (NUM_LINES - 1)) != 0) begin : g_num_lines_check
		$error("NUM_LINES must be a power of two, at least 2");
	end

	cache_state_e state_q;
	cache_state_e state_d;

	// set in the mem_ready cycle, marks the finish cycle after it
	logic finish_q;
	logic finish_d;

	logic req;
	// mem_ready taken for the first time
	logic mem_done;
	mem_addr_t req_line_addr;

	assign req = proc_read || proc_write;
	assign mem_done = mem_ready && !finish_q;
	// requested line, word offset dropped
	assign req_line_addr = proc_addr[PROC_ADDR_W-1:OFFSET_W];

	// --------------------------------------------------
	// next state
	// --------------------------------------------------

	always_comb begin
		state_d = state_q;
		finish_d = 1'b0;
		case (state_q)
			ST_IDLE: begin
				state_d = ST_COMPARE;
			end
			ST_COMPARE: begin
				// dirty victim goes out first
				if (req && !hit) begin
					state_d = line_dirty ? ST_WRITE_BACK : ST_ALLOCATE;
				end
			end
			ST_WRITE_BACK: begin
				// finish cycle, then fetch the new line
				if (finish_q) begin
					state_d = ST_ALLOCATE;
				end else if (mem_ready) begin
					finish_d = 1'b1;
				end
			end
			ST_ALLOCATE: begin
				// finish cycle, then retry the lookup
				if (finish_q) begin
					state_d = ST_COMPARE;
				end else if (mem_ready) begin
					finish_d = 1'b1;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	// --------------------------------------------------
	// outputs
	// --------------------------------------------------

	always_comb begin
		proc_stall = 1'b1;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		word_write_en = 1'b0;
		fill_en = 1'b0;
		clean_en = 1'b0;
		case (state_q)
			ST_COMPARE: begin
				// hit or no request lets the processor go
				proc_stall = req && !hit;
				word_write_en = proc_write && hit;
			end
			ST_WRITE_BACK: begin
				// strobe holds until mem_ready, low in the finish cycle
				mem_write = !finish_q;
				mem_addr = victim_mem_addr;
				mem_wdata = victim_line;
				clean_en = mem_done;
			end
			ST_ALLOCATE: begin
				mem_read = !finish_q;
				mem_addr = req_line_addr;
				// mem_rdata is valid with the pulse
				fill_en = mem_done;
			end
			default: begin
				// idle keeps the stall and nothing else
				proc_stall = 1'b1;
			end
		endcase
	end

	// --------------------------------------------------
	// state registers
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= ST_IDLE;
			finish_q <= 1'b0;
		end else begin
			state_q <= state_d;
			finish_q <= finish_d;
		end
	end

endmodule

`default_nettype wire

/* src/cache_geom_pkg.sv */
// address, word and line geometry of the cache, imported by every RTL file and the testbench
`default_nettype none

package cache_geom_pkg;

	// --------------------------------------------------
	// processor side
	// --------------------------------------------------

	// word address, byte offset already stripped
	localparam int PROC_ADDR_W = 30;
	localparam int WORD_W = 32;

	// --------------------------------------------------
	// line geometry
	// --------------------------------------------------

	localparam int WORDS_PER_LINE = 4;
	localparam int LINE_W = WORD_W * WORDS_PER_LINE;
	// word select inside one line
	localparam int OFFSET_W = $clog2(WORDS_PER_LINE);

	// memory side moves whole lines, so its address drops the word offset
	localparam int MEM_ADDR_W = PROC_ADDR_W - OFFSET_W;

	// one processor word
	typedef logic [WORD_W-1:0] word_t;
	// one full cache line, word 0 in the low bits
	typedef logic [LINE_W-1:0] line_t;
	// processor word address
	typedef logic [PROC_ADDR_W-1:0] proc_addr_t;
	// line address on the memory port
	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

endpackage

`default_nettype wire

/* src/cache_store.sv */
// tag, flag and data arrays of the direct-mapped cache, with lookup and line update
`timescale 1ns/1ps
`default_nettype none

module cache_store import cache_geom_pkg::*; #(
	parameter int NUM_LINES = 8
) (
	input logic clk,
	input logic proc_reset,

	// addressed request
	input proc_addr_t proc_addr,
	input word_t proc_wdata,

	// line returned by memory during allocate
	input line_t mem_rdata,

	// one-cycle update strobes from the controller
	input logic word_write_en,
	input logic fill_en,
	input logic clean_en,

	// lookup results for the addressed index
	output logic hit,
	output logic line_dirty,
	output word_t proc_rdata,

	// victim line and its home address for write-back
	output line_t victim_line,
	output mem_addr_t victim_mem_addr
);

	// --------------------------------------------------
	// address split
	// --------------------------------------------------

	localparam int INDEX_W = $clog2(NUM_LINES);
	localparam int TAG_W = PROC_ADDR_W - OFFSET_W - INDEX_W;

	logic [TAG_W-1:0] addr_tag;
	logic [INDEX_W-1:0] addr_index;
	logic [OFFSET_W-1:0] addr_offset;

	// tag | index | word offset
	assign addr_tag = proc_addr[PROC_ADDR_W-1 -: TAG_W];
	assign addr_index = proc_addr[OFFSET_W +: INDEX_W];
	assign addr_offset = proc_addr[OFFSET_W-1:0];

	// --------------------------------------------------
	// arrays
	// --------------------------------------------------

	// per-line flags
	logic [NUM_LINES-1:0] valid_q;
	logic [NUM_LINES-1:0] dirty_q;

	// per-line tag and payload
	logic [TAG_W-1:0] tag_q [NUM_LINES];
	line_t data_q [NUM_LINES];

	// addressed line with the write word merged in
	line_t merged_line;

	// --------------------------------------------------
	// lookup
	// --------------------------------------------------

	// hit needs a valid line with a matching tag
	assign hit = valid_q[addr_index] && (tag_q[addr_index] == addr_tag);

	// only a valid line can carry dirty data
	assign line_dirty = valid_q[addr_index] && dirty_q[addr_index];

	// word select, combinational so a read hit returns in the same cycle
	assign proc_rdata = data_q[addr_index][addr_offset * WORD_W +: WORD_W];

	// victim is whatever sits at the addressed index
	assign victim_line = data_q[addr_index];
	// stored tag plus index rebuilds the victim's line address
	assign victim_mem_addr = {tag_q[addr_index], addr_index};

	// --------------------------------------------------
	// word merge for write hits
	// --------------------------------------------------

	always_comb begin
		merged_line = data_q[addr_index];
		// replace just the addressed word
		merged_line[addr_offset * WORD_W +: WORD_W] = proc_wdata;
	end

	// --------------------------------------------------
	// flag update
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			// all lines invalid and clean after reset
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (fill_en || word_write_en) begin
				valid_q[addr_index] <= 1'b1;
			end
			// write hit marks dirty, fill or write-back leaves it clean
			if (word_write_en) begin
				dirty_q[addr_index] <= 1'b1;
			end else if (fill_en || clean_en) begin
				dirty_q[addr_index] <= 1'b0;
			end
		end
	end

	// --------------------------------------------------
	// tag and data update
	// --------------------------------------------------

	always_ff @(posedge clk) begin
		// fresh line from memory
		if (fill_en) begin
			data_q[addr_index] <= mem_rdata;
		end else if (word_write_en) begin
			data_q[addr_index] <= merged_line;
		end
		// both fill and word write claim the line for this tag
		if (fill_en || word_write_en) begin
			tag_q[addr_index] <= addr_tag;
		end
	end

endmodule

`default_nettype wire

/* src/cache_top.sv */
// top level of the write-back cache, joining the line store to its controller
`timescale 1ns/1ps
`default_nettype none

module cache_top import cache_geom_pkg::*; #(
	parameter int NUM_LINES = 8
) (
	input logic clk,
	input logic proc_reset,

	// --------------------------------------------------
	// processor port
	// --------------------------------------------------
	input logic proc_read,
	input logic proc_write,
	input proc_addr_t proc_addr,
	input word_t proc_wdata,
	output word_t proc_rdata,
	output logic proc_stall,

	// --------------------------------------------------
	// memory port
	// --------------------------------------------------
	output logic mem_read,
	output logic mem_write,
	output mem_addr_t mem_addr,
	output line_t mem_wdata,
	input line_t mem_rdata,
	input logic mem_ready
);

	// lookup, store to controller
	logic hit;
	logic line_dirty;

	// update strobes, controller to store
	logic word_write_en;
	logic fill_en;
	logic clean_en;

	// write-back payload and address
	line_t victim_line;
	mem_addr_t victim_mem_addr;

	// arrays and lookup
	cache_store #(
		.NUM_LINES(NUM_LINES)
	) u_store (
		.clk            (clk),
		.proc_reset     (proc_reset),
		.proc_addr      (proc_addr),
		.proc_wdata     (proc_wdata),
		.mem_rdata      (mem_rdata),
		.word_write_en  (word_write_en),
		.fill_en        (fill_en),
		.clean_en       (clean_en),
		.hit            (hit),
		.line_dirty     (line_dirty),
		.proc_rdata     (proc_rdata),
		.victim_line    (victim_line),
		.victim_mem_addr(victim_mem_addr)
	);

	// miss handling
	cache_fsm #(
		.NUM_LINES(NUM_LINES)
	) u_fsm (
		.clk            (clk),
		.proc_reset     (proc_reset),
		.proc_read      (proc_read),
		.proc_write     (proc_write),
		.hit            (hit),
		.line_dirty     (line_dirty),
		.mem_ready      (mem_ready),
		.victim_line    (victim_line),
		.victim_mem_addr(victim_mem_addr),
		.proc_addr      (proc_addr),
		.proc_stall     (proc_stall),
		.mem_read       (mem_read),
		.mem_write      (mem_write),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata),
		.word_write_en  (word_write_en),
		.fill_en        (fill_en),
		.clean_en       (clean_en)
	);

endmodule

`default_nettype wire

/* verification/cache_checker.sv */
// memory port and stall protocol assertions, bound into cache_top for every simulation
`timescale 1ns/1ps
`default_nettype none

module cache_checker import cache_geom_pkg::*; (
	input logic clk,
	input logic proc_reset,
	input logic proc_stall,
	input logic mem_read,
	input logic mem_write,
	input mem_addr_t mem_addr,
	input logic mem_ready
);

	// failed assertions so far, summed into the testbench counts
	int violations = 0;

	// --------------------------------------------------
	// memory strobes
	// --------------------------------------------------

	// one strobe at a time
	a_one_strobe: assert property (@(posedge clk) disable iff (proc_reset)
		!(mem_read && mem_write))
		else begin
			violations++;
			$error("mem_read and mem_write high together");
		end

	// processor waits while memory works
	a_stall_on_strobe: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read || mem_write) |-> proc_stall)
		else begin
			violations++;
			$error("memory strobe high with proc_stall low");
		end

	// strobe and address held until mem_ready
	a_addr_stable: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read || mem_write) && !mem_ready |=>
		$stable(mem_addr) && $stable(mem_read) && $stable(mem_write))
		else begin
			violations++;
			$error("strobe or mem_addr changed before mem_ready");
		end

	// idle cycle right after reset
	a_quiet_after_reset: assert property (@(posedge clk)
		$fell(proc_reset) |-> !mem_read && !mem_write)
		else begin
			violations++;
			$error("memory strobe in the cycle after reset");
		end

endmodule

bind cache_top cache_checker u_checker (
	.clk       (clk),
	.proc_reset(proc_reset),
	.proc_stall(proc_stall),
	.mem_read  (mem_read),
	.mem_write (mem_write),
	.mem_addr  (mem_addr),
	.mem_ready (mem_ready)
);

`default_nettype wire

/* verification/cache_tb.sv */
// testbench of the cache: slow memory model, shadow reference and directed plus random traffic
`timescale 1ns/1ps
`default_nettype none

module cache_tb import cache_geom_pkg::*; ();

	localparam int NUM_LINES = 8;
	localparam int TIMEOUT = 100;

	logic clk;
	logic proc_reset;
	logic proc_read;
	logic proc_write;
	proc_addr_t proc_addr;
	word_t proc_wdata;
	word_t proc_rdata;
	logic proc_stall;
	logic mem_read;
	logic mem_write;
	mem_addr_t mem_addr;
	line_t mem_wdata;
	line_t mem_rdata;
	logic mem_ready;

	logic [31:0] lfsr_q = 32'h71b3_be7d;
	// memory model store and shadow reference
	line_t mem_lines [mem_addr_t];
	word_t shadow [proc_addr_t];
	// memory traffic seen by the model
	int rd_count = 0;
	int wr_count = 0;
	mem_addr_t last_rd_addr;
	mem_addr_t last_wb_addr;
	line_t last_wb_line;
	string test_name;
	int pass_count = 0;
	int fail_count = 0;
	// set once an access never got past the stall
	bit timed_out = 1'b0;

	cache_top #(
		.NUM_LINES(NUM_LINES)
	) u_dut (
		.clk(clk), .proc_reset(proc_reset),
		.proc_read(proc_read), .proc_write(proc_write),
		.proc_addr(proc_addr), .proc_wdata(proc_wdata),
		.proc_rdata(proc_rdata), .proc_stall(proc_stall),
		.mem_read(mem_read), .mem_write(mem_write),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata), .mem_ready(mem_ready)
	);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------------------------------------
	// random source and reference
	// --------------------------------------------------

	// galois step, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit, lsb first
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v[i] = lfsr_q[0];
		end
		return v;
	endfunction

	// contents of a never written word, depends on all address bits
	function automatic word_t addr_pattern(input proc_addr_t a);
		return {2'b01, a} ^ 32'hc3a5_0f1e;
	endfunction

	// last write wins, else the pattern
	function automatic word_t expected_word(input proc_addr_t a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end else begin
			return addr_pattern(a);
		end
	endfunction

	function automatic line_t expected_line(input mem_addr_t la);
		line_t l;
		int i;
		for (i = 0; i < WORDS_PER_LINE; i++) begin
			l[i*WORD_W +: WORD_W] = expected_word({la, 2'(i)});
		end
		return l;
	endfunction

	// line from the memory store, pattern words if never written back
	function automatic line_t fetch_line(input mem_addr_t la);
		line_t l;
		int i;
		if (mem_lines.exists(la)) begin
			l = mem_lines[la];
		end else begin
			for (i = 0; i < WORDS_PER_LINE; i++) begin
				l[i*WORD_W +: WORD_W] = addr_pattern({la, 2'(i)});
			end
		end
		return l;
	endfunction

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------

	task automatic report(input string name, input bit ok, input string exp_s, input string act_s);
		if (ok) begin
			pass_count++;
			$display("pass  %s", name);
		end else begin
			fail_count++;
			$display("ERROR %s expected %s actual %s", name, exp_s, act_s);
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		report(name, exp === act, $sformatf("%h", exp), $sformatf("%h", act));
	endtask

	task automatic check_line(input string name, input line_t exp, input line_t act);
		report(name, exp === act, $sformatf("%h", exp), $sformatf("%h", act));
	endtask

	task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
		report(name, exp === act, $sformatf("%h", exp), $sformatf("%h", act));
	endtask

	// conditions that have no single expected value
	task automatic check_cond(input string name, input bit ok, input string what);
		if (ok) begin
			pass_count++;
			$display("pass  %s", name);
		end else begin
			fail_count++;
			$display("FAIL  %s: %s", name, what);
		end
	endtask

	// --------------------------------------------------
	// slow memory model
	// --------------------------------------------------

	// answers each strobe after 1 to 4 cycles with a one-cycle mem_ready
	initial begin
		bit armed;
		int delay_left;
		armed = 1'b0;
		delay_left = 0;
		mem_ready = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clk);
			mem_ready <= 1'b0;
			if (proc_reset) begin
				armed = 1'b0;
			end else if ((mem_read || mem_write) && !mem_ready) begin
				if (!armed) begin
					armed = 1'b1;
					delay_left = 1 + int'(rand_bits(2));
				end else if (delay_left > 1) begin
					delay_left = delay_left - 1;
				end else begin
					armed = 1'b0;
					mem_ready <= 1'b1;
					if (mem_read) begin
						rd_count++;
						last_rd_addr = mem_addr;
						mem_rdata <= fetch_line(mem_addr);
					end else begin
						wr_count++;
						last_wb_addr = mem_addr;
						last_wb_line = mem_wdata;
						mem_lines[mem_addr] = mem_wdata;
					end
				end
			end
		end
	end

	// read results against the shadow, writes into the shadow
	initial begin
		forever begin
			@(negedge clk);
			if (!proc_reset && !proc_stall && proc_read) begin
				check_word(test_name, expected_word(proc_addr), proc_rdata);
			end
			if (!proc_reset && !proc_stall && proc_write) begin
				shadow[proc_addr] = proc_wdata;
			end
		end
	end

	// one processor access, held until proc_stall drops
	task automatic access(input bit is_write, input proc_addr_t addr, input word_t wdata);
		int n;
		n = 0;
		// a hung controller ends all further traffic
		if (!timed_out) begin
			@(posedge clk);
			proc_read <= !is_write;
			proc_write <= is_write;
			proc_addr <= addr;
			proc_wdata <= wdata;
			@(negedge clk);
			while (proc_stall && n < TIMEOUT) begin
				@(negedge clk);
				n++;
			end
			if (proc_stall) begin
				timed_out = 1'b1;
				fail_count++;
				$display("timeout: access to %h still stalled after %0d cycles", addr, TIMEOUT);
			end else begin
				@(posedge clk);
				proc_read <= 1'b0;
				proc_write <= 1'b0;
			end
		end
	endtask

	// --------------------------------------------------
	// directed and random sequence
	// --------------------------------------------------

	initial begin
		proc_addr_t addr;
		word_t wdata;
		bit op_write;
		int n_rd;
		int n_wr;
		int k;
		proc_reset = 1'b1;
		proc_read = 1'b0;
		proc_write = 1'b0;
		proc_addr = '0;
		proc_wdata = '0;
		test_name = "";
		repeat (2) @(posedge clk);
		proc_reset <= 1'b0;

		// idle cycle, then first read
		@(negedge clk);
		check_cond("idle after reset", proc_stall && !mem_read && !mem_write,
			"proc_stall low or a memory strobe high in the idle cycle");
		test_name = "first read";
		access(1'b0, 30'h40, '0);

		// miss on line 0x11
		test_name = "read miss pattern";
		access(1'b0, 30'h46, '0);
		check_addr("read miss line address", 28'h11, last_rd_addr);

		// same line again, no memory traffic
		n_rd = rd_count;
		n_wr = wr_count;
		test_name = "read hit same line";
		access(1'b0, 30'h45, '0);
		check_cond("hit without memory", rd_count == n_rd && wr_count == n_wr,
			"memory strobe on a read hit");

		// write hit, readback and neighbours
		test_name = "write then read";
		access(1'b1, 30'h47, 32'hdead_beef);
		access(1'b0, 30'h47, '0);
		test_name = "line neighbours kept";
		access(1'b0, 30'h44, '0);
		access(1'b0, 30'h45, '0);
		access(1'b0, 30'h46, '0);
		check_cond("write hit without memory", rd_count == n_rd && wr_count == n_wr,
			"memory strobe during write hit or readback");

		// line 0x19 shares index 1 with dirty line 0x11
		test_name = "conflict read";
		access(1'b0, 30'h64, '0);
		check_addr("write-back line address", 28'h11, last_wb_addr);
		check_line("write-back line", expected_line(28'h11), last_wb_line);
		test_name = "reread evicted word";
		access(1'b0, 30'h47, '0);

		// 16 lines over 8 slots
		test_name = "random traffic";
		for (k = 0; k < 200; k++) begin
			op_write = rand_bits(1) != 0;
			addr = proc_addr_t'(rand_bits(6));
			wdata = rand_bits(32);
			access(op_write, addr, wdata);
		end

		check_cond("protocol assertions", u_dut.u_checker.violations == 0,
			"a bound protocol assertion failed");
		$display("summary: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
src/cache_geom_pkg.sv
src/cache_ctrl_pkg.sv
src/cache_store.sv
src/cache_fsm.sv
src/cache_top.sv
verification/cache_checker.sv
verification/cache_tb.sv
